// ==== hdl/udp_echo_pkg.sv ====
// Field types and protocol constants shared by the UDP echo endpoint.

package udp_echo_pkg;

   // One byte of the frame stream.
   typedef logic [7:0] byte_t;

   // Ethernet MAC address.
   typedef logic [47:0] mac_addr_t;

   // IPv4 address.
   typedef logic [31:0] ip_addr_t;

   // UDP port number.
   typedef logic [15:0] udp_port_t;

   // Length or checksum field, 16 bits wide.
   typedef logic [15:0] len16_t;

   // Header sizes in bytes. The IPv4 header carries no options.
   localparam int ETH_HDR_BYTES = 14;
   localparam int IP_HDR_BYTES  = 20;
   localparam int UDP_HDR_BYTES = 8;

   // Ethernet, IPv4 and UDP headers back to back.
   localparam int HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

   // Ethertype of an IPv4 packet.
   localparam len16_t ETHERTYPE_IPV4 = 16'h0800;

   // IP protocol number of UDP.
   localparam byte_t IP_PROTO_UDP = 8'd17;

   // Destination port that gets echoed.
   localparam udp_port_t ECHO_PORT = 16'd1234;

   // Time to live placed in every echoed packet.
   localparam byte_t ECHO_TTL = 8'd64;

endpackage

// ==== hdl/frame_rx_parser.sv ====
// Receive parser that splits a frame into header fields and a payload stream.

`timescale 1ns/1ns
`default_nettype none

module frame_rx_parser (
   input  var logic                   clk,
   input  var logic                   reset,

   input  var udp_echo_pkg::byte_t    in_data,
   input  var logic                   in_valid,
   output var logic                   in_ready,
   input  var logic                   in_last,

   output var logic                   hdr_valid,
   input  var logic                   hdr_ready,
   output var udp_echo_pkg::mac_addr_t dst_mac,
   output var udp_echo_pkg::mac_addr_t src_mac,
   output var udp_echo_pkg::len16_t   ethertype,
   output var udp_echo_pkg::byte_t    ip_proto,
   output var udp_echo_pkg::ip_addr_t src_ip,
   output var udp_echo_pkg::ip_addr_t dst_ip,
   output var udp_echo_pkg::udp_port_t src_port,
   output var udp_echo_pkg::udp_port_t dst_port,
   output var udp_echo_pkg::len16_t   udp_len,

   output var udp_echo_pkg::byte_t    pl_data,
   output var logic                   pl_valid,
   input  var logic                   pl_ready,
   output var logic                   pl_last,

   output var logic                   rx_short
);
   import udp_echo_pkg::*;

   typedef enum logic [1:0] {
      RX_HEADER,
      RX_HOLD,
      RX_PAYLOAD
   } rx_state_t;

   rx_state_t  state;
   logic [5:0] cnt;   // Offset of the next header byte.

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= RX_HEADER;
         cnt      <= '0;
         rx_short <= 1'b0;
      end else begin
         rx_short <= 1'b0;
         case (state)
            RX_HEADER: begin
               if (in_valid) begin
                  if (in_last) begin
                     // Frame ended inside the header, start over.
                     rx_short <= 1'b1;
                     cnt      <= '0;
                  end else if (cnt == HDR_BYTES - 1) begin
                     state <= RX_HOLD;
                     cnt   <= '0;
                  end else begin
                     cnt <= cnt + 6'd1;
                  end
               end
            end
            RX_HOLD: begin
               if (hdr_ready) state <= RX_PAYLOAD;
            end
            RX_PAYLOAD: begin
               if (in_valid && pl_ready && in_last) state <= RX_HEADER;
            end
            default: state <= RX_HEADER;
         endcase
      end
   end

   // Header bytes arrive most significant first, so each field shifts left.
   always_ff @(posedge clk) begin
      if (state == RX_HEADER && in_valid) begin
         if (cnt < 6) begin
            dst_mac <= {dst_mac[39:0], in_data};
         end else if (cnt < 12) begin
            src_mac <= {src_mac[39:0], in_data};
         end else if (cnt < ETH_HDR_BYTES) begin
            ethertype <= {ethertype[7:0], in_data};
         end else if (cnt == ETH_HDR_BYTES + 9) begin
            ip_proto <= in_data;
         end else if (cnt >= ETH_HDR_BYTES + 12 && cnt < ETH_HDR_BYTES + 16) begin
            src_ip <= {src_ip[23:0], in_data};
         end else if (cnt >= ETH_HDR_BYTES + 16 && cnt < ETH_HDR_BYTES + IP_HDR_BYTES) begin
            dst_ip <= {dst_ip[23:0], in_data};
         end else if (cnt >= HDR_BYTES - 8 && cnt < HDR_BYTES - 6) begin
            src_port <= {src_port[7:0], in_data};
         end else if (cnt >= HDR_BYTES - 6 && cnt < HDR_BYTES - 4) begin
            dst_port <= {dst_port[7:0], in_data};
         end else if (cnt >= HDR_BYTES - 4 && cnt < HDR_BYTES - 2) begin
            udp_len <= {udp_len[7:0], in_data};
         end
      end
   end

   assign hdr_valid = (state == RX_HOLD);

   // Payload passes straight through once the header is gone.
   assign pl_data  = in_data;
   assign pl_last  = in_last;
   assign pl_valid = (state == RX_PAYLOAD) && in_valid;
   assign in_ready = (state == RX_HEADER) || ((state == RX_PAYLOAD) && pl_ready);

   hdr_hold_a: assert property (@(posedge clk) disable iff (reset)
      hdr_valid && !hdr_ready |=> hdr_valid)
      else $error("hdr_valid fell before the header was accepted.");

endmodule

`default_nettype wire

// ==== hdl/udp_loopback.sv ====
// Echo match logic, header field swap and payload gating per frame.

`timescale 1ns/1ns
`default_nettype none

module udp_loopback (
   input  var logic                    clk,
   input  var logic                    reset,
   input  var udp_echo_pkg::mac_addr_t local_mac,
   input  var udp_echo_pkg::ip_addr_t  local_ip,

   input  var logic                    hdr_valid,
   output var logic                    hdr_ready,
   input  var udp_echo_pkg::mac_addr_t dst_mac,
   input  var udp_echo_pkg::mac_addr_t src_mac,
   input  var udp_echo_pkg::len16_t    ethertype,
   input  var udp_echo_pkg::byte_t     ip_proto,
   input  var udp_echo_pkg::ip_addr_t  src_ip,
   input  var udp_echo_pkg::ip_addr_t  dst_ip,
   input  var udp_echo_pkg::udp_port_t src_port,
   input  var udp_echo_pkg::udp_port_t dst_port,
   input  var udp_echo_pkg::len16_t    udp_len,

   input  var udp_echo_pkg::byte_t     pl_data,
   input  var logic                    pl_valid,
   output var logic                    pl_ready,
   input  var logic                    pl_last,

   output var logic                    tx_hdr_valid,
   input  var logic                    tx_hdr_ready,
   output var udp_echo_pkg::mac_addr_t eth_dst,
   output var udp_echo_pkg::ip_addr_t  ip_dst,
   output var udp_echo_pkg::udp_port_t port_src,
   output var udp_echo_pkg::udp_port_t port_dst,
   output var udp_echo_pkg::len16_t    tx_udp_len,

   output var udp_echo_pkg::byte_t     tx_pl_data,
   output var logic                    tx_pl_valid,
   input  var logic                    tx_pl_ready,
   output var logic                    tx_pl_last,

   output var logic                    rx_drop
);
   import udp_echo_pkg::*;

   logic match;
   logic fwd_reg;    // Payload of the current frame goes to the builder.
   logic drop_reg;   // Payload of the current frame is thrown away.

   assign match = (dst_mac == local_mac) && (ethertype == ETHERTYPE_IPV4) &&
                  (ip_proto == IP_PROTO_UDP) && (dst_ip == local_ip) &&
                  (dst_port == ECHO_PORT);

   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_reg  <= 1'b0;
         drop_reg <= 1'b0;
      end else if (hdr_valid && hdr_ready) begin
         fwd_reg  <= match;
         drop_reg <= !match;
      end else if (pl_valid && pl_ready && pl_last) begin
         fwd_reg  <= 1'b0;
         drop_reg <= 1'b0;
      end
   end

   // A dropped header is taken at once; an echoed one waits for the builder.
   assign hdr_ready    = match ? tx_hdr_ready : 1'b1;
   assign tx_hdr_valid = hdr_valid && match;
   assign rx_drop      = hdr_valid && hdr_ready && !match;

   assign eth_dst    = src_mac;
   assign ip_dst     = src_ip;
   assign port_src   = dst_port;
   assign port_dst   = src_port;
   assign tx_udp_len = udp_len;

   assign tx_pl_data  = pl_data;
   assign tx_pl_last  = pl_last;
   assign tx_pl_valid = pl_valid && fwd_reg;
   assign pl_ready    = (tx_pl_ready && fwd_reg) || drop_reg;

   verdict_a: assert property (@(posedge clk) disable iff (reset)
      pl_valid |-> (fwd_reg ^ drop_reg))
      else $error("Payload byte seen without exactly one verdict held.");

endmodule

`default_nettype wire

// ==== hdl/frame_tx_builder.sv ====
// Transmit builder that checksums and serializes the echo header, then the payload.

`timescale 1ns/1ns
`default_nettype none

module frame_tx_builder (
   input  var logic                    clk,
   input  var logic                    reset,
   input  var udp_echo_pkg::mac_addr_t local_mac,
   input  var udp_echo_pkg::ip_addr_t  local_ip,

   input  var logic                    tx_hdr_valid,
   output var logic                    tx_hdr_ready,
   input  var udp_echo_pkg::mac_addr_t eth_dst,
   input  var udp_echo_pkg::ip_addr_t  ip_dst,
   input  var udp_echo_pkg::udp_port_t port_src,
   input  var udp_echo_pkg::udp_port_t port_dst,
   input  var udp_echo_pkg::len16_t    udp_len,

   input  var udp_echo_pkg::byte_t     tx_pl_data,
   input  var logic                    tx_pl_valid,
   output var logic                    tx_pl_ready,
   input  var logic                    tx_pl_last,

   output var udp_echo_pkg::byte_t     out_data,
   output var logic                    out_valid,
   input  var logic                    out_ready,
   output var logic                    out_last
);
   import udp_echo_pkg::*;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_SUM,
      TX_HEADER,
      TX_PAYLOAD
   } tx_state_t;

   tx_state_t  state;
   logic [5:0] idx;   // Header byte now on the output.

   mac_addr_t  eth_dst_r;
   ip_addr_t   ip_dst_r;
   udp_port_t  port_src_r;
   udp_port_t  port_dst_r;
   len16_t     udp_len_r;
   len16_t     ip_csum;

   len16_t     total_len;
   logic [19:0] sum;
   logic [16:0] fold;
   logic [HDR_BYTES*8-1:0] hdr_vec;

   assign total_len = udp_len_r + len16_t'(IP_HDR_BYTES);

   // Ones' complement sum of the ten IPv4 header words, checksum word as zero.
   assign sum = 20'h04500 + 20'(total_len) + 20'({ECHO_TTL, IP_PROTO_UDP}) +
                20'(local_ip[31:16]) + 20'(local_ip[15:0]) +
                20'(ip_dst_r[31:16]) + 20'(ip_dst_r[15:0]);
   assign fold = 17'(sum[15:0]) + 17'(sum[19:16]);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= TX_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (tx_hdr_valid) state <= TX_SUM;
            end
            TX_SUM: begin
               state <= TX_HEADER;
            end
            TX_HEADER: begin
               if (out_ready) begin
                  if (idx == HDR_BYTES - 1) begin
                     state <= TX_PAYLOAD;
                     idx   <= '0;
                  end else begin
                     idx <= idx + 6'd1;
                  end
               end
            end
            TX_PAYLOAD: begin
               if (tx_pl_valid && out_ready && tx_pl_last) state <= TX_IDLE;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_hdr_valid) begin
         eth_dst_r  <= eth_dst;
         ip_dst_r   <= ip_dst;
         port_src_r <= port_src;
         port_dst_r <= port_dst;
         udp_len_r  <= udp_len;
      end
      if (state == TX_SUM) begin
         ip_csum <= ~(fold[15:0] + 16'(fold[16]));   // Second carry fold.
      end
   end

   // Whole header, first byte in the top bits. Identification and fragment are zero.
   assign hdr_vec = {eth_dst_r, local_mac, ETHERTYPE_IPV4,
                     8'h45, 8'h00, total_len, 16'h0000, 16'h0000,
                     ECHO_TTL, IP_PROTO_UDP, ip_csum, local_ip, ip_dst_r,
                     port_src_r, port_dst_r, udp_len_r, 16'h0000};

   assign tx_hdr_ready = (state == TX_IDLE);
   assign tx_pl_ready  = (state == TX_PAYLOAD) && out_ready;

   always_comb begin
      case (state)
         TX_HEADER: begin
            out_data  = hdr_vec[(HDR_BYTES - 1 - idx) * 8 +: 8];
            out_valid = 1'b1;
            out_last  = 1'b0;
         end
         TX_PAYLOAD: begin
            out_data  = tx_pl_data;
            out_valid = tx_pl_valid;
            out_last  = tx_pl_last;
         end
         default: begin
            out_data  = '0;
            out_valid = 1'b0;
            out_last  = 1'b0;
         end
      endcase
   end

   // Holds for header bytes here and for payload bytes held by the upstream blocks.
   out_stable_a: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> $stable(out_data))
      else $error("out_data changed while stalled by out_ready.");

endmodule

`default_nettype wire

// ==== hdl/udp_echo_top.sv ====
// Top level of the UDP echo endpoint with parser, loopback and builder.

`timescale 1ns/1ns
`default_nettype none

module udp_echo_top (
   input  var logic                    clk,
   input  var logic                    reset,
   input  var udp_echo_pkg::mac_addr_t local_mac,
   input  var udp_echo_pkg::ip_addr_t  local_ip,

   input  var udp_echo_pkg::byte_t     in_data,
   input  var logic                    in_valid,
   output var logic                    in_ready,
   input  var logic                    in_last,

   output var udp_echo_pkg::byte_t     out_data,
   output var logic                    out_valid,
   input  var logic                    out_ready,
   output var logic                    out_last,

   output var logic                    rx_drop,
   output var logic                    rx_short
);
   import udp_echo_pkg::*;

   // Parser to loopback.
   logic hdr_valid, hdr_ready;
   mac_addr_t dst_mac, src_mac;
   len16_t ethertype, udp_len;
   byte_t ip_proto, pl_data;
   ip_addr_t src_ip, dst_ip;
   udp_port_t src_port, dst_port;
   logic pl_valid, pl_ready, pl_last;

   // Loopback to builder.
   logic tx_hdr_valid, tx_hdr_ready;
   mac_addr_t eth_dst;
   ip_addr_t ip_dst;
   udp_port_t port_src, port_dst;
   len16_t tx_udp_len;
   byte_t tx_pl_data;
   logic tx_pl_valid, tx_pl_ready, tx_pl_last;

   frame_rx_parser i_frame_rx_parser (
      .clk(clk), .reset(reset),
      .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready), .in_last(in_last),
      .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
      .dst_mac(dst_mac), .src_mac(src_mac), .ethertype(ethertype), .ip_proto(ip_proto),
      .src_ip(src_ip), .dst_ip(dst_ip), .src_port(src_port), .dst_port(dst_port),
      .udp_len(udp_len),
      .pl_data(pl_data), .pl_valid(pl_valid), .pl_ready(pl_ready), .pl_last(pl_last),
      .rx_short(rx_short)
   );

   udp_loopback i_udp_loopback (
      .clk(clk), .reset(reset), .local_mac(local_mac), .local_ip(local_ip),
      .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
      .dst_mac(dst_mac), .src_mac(src_mac), .ethertype(ethertype), .ip_proto(ip_proto),
      .src_ip(src_ip), .dst_ip(dst_ip), .src_port(src_port), .dst_port(dst_port),
      .udp_len(udp_len),
      .pl_data(pl_data), .pl_valid(pl_valid), .pl_ready(pl_ready), .pl_last(pl_last),
      .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
      .eth_dst(eth_dst), .ip_dst(ip_dst), .port_src(port_src), .port_dst(port_dst),
      .tx_udp_len(tx_udp_len),
      .tx_pl_data(tx_pl_data), .tx_pl_valid(tx_pl_valid), .tx_pl_ready(tx_pl_ready),
      .tx_pl_last(tx_pl_last),
      .rx_drop(rx_drop)
   );

   frame_tx_builder i_frame_tx_builder (
      .clk(clk), .reset(reset), .local_mac(local_mac), .local_ip(local_ip),
      .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
      .eth_dst(eth_dst), .ip_dst(ip_dst), .port_src(port_src), .port_dst(port_dst),
      .udp_len(tx_udp_len),
      .tx_pl_data(tx_pl_data), .tx_pl_valid(tx_pl_valid), .tx_pl_ready(tx_pl_ready),
      .tx_pl_last(tx_pl_last),
      .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
      .out_last(out_last)
   );

endmodule

`default_nettype wire

// ==== dv/udp_echo_tb.sv ====
// Testbench for the UDP echo endpoint with frame table, reference model, monitor and watchdog.

`timescale 1ns/1ns

module udp_echo_tb;

   localparam int OUT_ECHO  = 0;
   localparam int OUT_DROP  = 1;
   localparam int OUT_SHORT = 2;

   localparam int HDR_LEN = 42;

   localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01;
   localparam logic [31:0] LOCAL_IP  = 32'hc0a8_010a;
   localparam logic [47:0] PEER_MAC  = 48'h02_00_00_00_00_99;
   localparam logic [31:0] PEER_IP   = 32'hc0a8_0164;

   typedef struct {
      logic [47:0] dst_mac;
      logic [15:0] etype;
      logic [7:0]  proto;
      logic [31:0] dst_ip;
      logic [15:0] dst_port;
      int          pl_len;
      bit          stall;
      int          trunc;   // Length the frame is cut to. Zero sends it whole.
      int          outcome;
   } frame_entry_t;

   logic        clk;
   logic        reset;
   logic [47:0] local_mac;
   logic [31:0] local_ip;
   logic [7:0]  in_data;
   logic        in_valid, in_ready, in_last;
   logic [7:0]  out_data;
   logic        out_valid, out_ready, out_last;
   logic        rx_drop, rx_short;

   frame_entry_t tbl[$];
   logic [7:0]   frame_q[$];
   logic [7:0]   exp_q[$];
   logic [7:0]   got_q[$];
   bit           got_last_q[$];
   int           drop_cnt, short_cnt, test_errs, total_errs, failed_tests;
   bit           stall_en;
   bit           stall_now;
   logic [31:0]  pl_lfsr, stall_lfsr;

   udp_echo_top i_udp_echo_top (
      .clk(clk), .reset(reset), .local_mac(local_mac), .local_ip(local_ip),
      .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready), .in_last(in_last),
      .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
      .out_last(out_last), .rx_drop(rx_drop), .rx_short(rx_short)
   );

   always #50 clk = ~clk;

   // Outputs are settled at the falling edge, ahead of the edge where a byte moves.
   always @(negedge clk) begin
      if (out_valid && out_ready) begin
         got_q.push_back(out_data);
         got_last_q.push_back(out_last);
      end
      if (rx_drop) drop_cnt++;
      if (rx_short) short_cnt++;
   end

   // The stall mode is taken at the edge, before the test loop can change it.
   always @(posedge clk) begin
      stall_now = stall_en;
      #10;
      if (stall_now) begin
         stall_lfsr = lfsr_step(stall_lfsr);
         out_ready  = stall_lfsr[0];
      end else begin
         out_ready = 1'b1;
      end
   end

   // Taps 32, 22, 2 and 1; the new bit enters at the bottom.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Ones' complement sum of the ten IPv4 header words starting at byte first.
   function automatic logic [15:0] ones_sum(input logic [7:0] q[$], input int first);
      logic [31:0] acc;
      acc = 0;
      for (int i = 0; i < 10; i++) acc += {q[first + 2 * i], q[first + 2 * i + 1]};
      while (acc[31:16] != 0) acc = acc[15:0] + acc[31:16];
      return acc[15:0];
   endfunction

   task automatic add_entry(input logic [47:0] mac, input logic [15:0] etype,
                            input logic [7:0] proto, input logic [31:0] ip,
                            input logic [15:0] port, input int len, input bit stall,
                            input int trunc, input int outcome);
      frame_entry_t e;
      e = '{mac, etype, proto, ip, port, len, stall, trunc, outcome};
      tbl.push_back(e);
   endtask

   // Builds the sent frame and the echo that the rules call for.
   task automatic build_frame(input frame_entry_t e, input int k);
      logic [HDR_LEN*8-1:0] sent_hdr;
      logic [HDR_LEN*8-1:0] echo_hdr;
      logic [7:0]  b;
      logic [15:0] csum;
      logic [15:0] ulen;
      logic [15:0] peer_port;
      frame_q.delete();
      exp_q.delete();
      ulen      = 16'(8 + e.pl_len);
      peer_port = 16'(5000 + k);
      sent_hdr = {e.dst_mac, PEER_MAC, e.etype,
                  16'h4500, ulen + 16'd20, 32'h1c46_4000, 8'h80, e.proto, 16'hbeef,
                  PEER_IP, e.dst_ip,
                  peer_port, e.dst_port, ulen, 16'habcd};
      echo_hdr = {PEER_MAC, LOCAL_MAC, 16'h0800,
                  16'h4500, ulen + 16'd20, 32'h0, 8'd64, 8'd17, 16'h0,
                  LOCAL_IP, PEER_IP,
                  e.dst_port, peer_port, ulen, 16'h0};
      for (int i = HDR_LEN - 1; i >= 0; i--) begin
         frame_q.push_back(sent_hdr[8 * i +: 8]);
         exp_q.push_back(echo_hdr[8 * i +: 8]);
      end
      csum = ~ones_sum(exp_q, 14);
      exp_q[24] = csum[15:8];
      exp_q[25] = csum[7:0];
      for (int i = 0; i < e.pl_len; i++) begin
         for (int j = 0; j < 8; j++) begin
            pl_lfsr = lfsr_step(pl_lfsr);
            b = {b[6:0], pl_lfsr[0]};
         end
         frame_q.push_back(b);
         exp_q.push_back(b);
      end
      if (e.trunc > 0) while (frame_q.size() > e.trunc) void'(frame_q.pop_back());
   endtask

   // Each byte waits until in_ready is seen, then moves on the next rising edge.
   task automatic send_frame();
      bit accepted;
      for (int i = 0; i < frame_q.size(); i++) begin
         in_data  = frame_q[i];
         in_valid = 1'b1;
         in_last  = (i == frame_q.size() - 1);
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #10;
         end
      end
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   initial begin
      frame_entry_t e;
      longint       wd_cycles;
      int           n, exp_drop, exp_short;
      clk          = 0;
      reset        = 1;
      in_data      = '0;
      in_valid     = 0;
      in_last      = 0;
      out_ready    = 1;
      local_mac    = LOCAL_MAC;
      local_ip     = LOCAL_IP;
      stall_en     = 0;
      pl_lfsr      = 32'hca91;
      stall_lfsr   = 32'hca91;
      total_errs   = 0;
      failed_tests = 0;
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 10, 0, 0, OUT_ECHO);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 33, 1, 0, OUT_ECHO);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1235, 12, 0, 0, OUT_DROP);
      add_entry(48'h02_00_00_00_00_02, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 12, 0, 0, OUT_DROP);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, 32'hc0a8_010b, 16'd1234, 12, 0, 0, OUT_DROP);
      add_entry(LOCAL_MAC, 16'h86dd, 8'd17, LOCAL_IP, 16'd1234, 12, 0, 0, OUT_DROP);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 16, 0, 0, OUT_ECHO);
      add_entry(LOCAL_MAC, 16'h0800, 8'd6, LOCAL_IP, 16'd1234, 12, 0, 0, OUT_DROP);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 64, 1, 0, OUT_ECHO);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 8, 0, 20, OUT_SHORT);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 8, 0, 42, OUT_SHORT);
      add_entry(LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, 16'd1234, 1, 1, 0, OUT_ECHO);
      wd_cycles = 200 * tbl.size() + 4;
      foreach (tbl[k]) wd_cycles += tbl[k].pl_len;
      fork
         begin
            #(wd_cycles * 100);
            $display("Watchdog timeout: the run did not finish in time.");
            $display("Errors found");
            $finish;
         end
      join_none
      repeat (4) @(posedge clk);
      #10;
      reset = 0;
      foreach (tbl[k]) begin
         e = tbl[k];
         test_errs = 0;
         drop_cnt  = 0;
         short_cnt = 0;
         got_q.delete();
         got_last_q.delete();
         stall_en = e.stall;
         build_frame(e, k);
         send_frame();
         n = 0;
         if (e.outcome == OUT_ECHO) begin
            while ((got_last_q.size() == 0 || !got_last_q[$]) && n < 400 + 4 * e.pl_len) begin
               @(posedge clk);
               n++;
            end
         end
         repeat (4) @(posedge clk);
         #10;
         exp_drop  = (e.outcome == OUT_DROP);
         exp_short = (e.outcome == OUT_SHORT);
         assert (drop_cnt == exp_drop) else begin
            $display("Error: at %0t ns rx_drop pulses expected %0d, got %0d", $time, exp_drop,
                     drop_cnt);
            test_errs++;
         end
         assert (short_cnt == exp_short) else begin
            $display("Error: at %0t ns rx_short pulses expected %0d, got %0d", $time, exp_short,
                     short_cnt);
            test_errs++;
         end
         if (e.outcome == OUT_ECHO) begin
            assert (got_q.size() == exp_q.size()) else begin
               $display("Error: at %0t ns out_data byte count expected %0d, got %0d", $time,
                        exp_q.size(), got_q.size());
               test_errs++;
            end
            for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
               assert (got_q[i] == exp_q[i]) else begin
                  $display("Error: at %0t ns out_data[%0d] expected 8'h%h, got 8'h%h", $time, i,
                           exp_q[i], got_q[i]);
                  test_errs++;
               end
               assert (got_last_q[i] == (i == exp_q.size() - 1)) else begin
                  $display("Error: at %0t ns out_last at byte %0d expected %0d, got %0d", $time,
                           i, (i == exp_q.size() - 1), got_last_q[i]);
                  test_errs++;
               end
            end
            // A valid header sums to all ones including its own checksum.
            if (got_q.size() >= 34) begin
               assert (ones_sum(got_q, 14) == 16'hffff) else begin
                  $display("Error: at %0t ns out_data ip header sum expected 16'hffff, got 16'h%h",
                           $time, ones_sum(got_q, 14));
                  test_errs++;
               end
            end
         end else begin
            assert (got_q.size() == 0) else begin
               $display("A frame that should be discarded came out as %0d bytes.", got_q.size());
               test_errs++;
            end
         end
         total_errs += test_errs;
         if (test_errs != 0) failed_tests++;
         $display("Test %0d: outcome %0d, %0d payload bytes, %s", k, e.outcome, e.pl_len,
                  (test_errs == 0) ? "pass" : "FAIL");
      end
      $display("Tests run %0d, tests failed %0d, failed checks %0d", tbl.size(), failed_tests,
               total_errs);
      if (total_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== project.f ====
hdl/udp_echo_pkg.sv
hdl/frame_rx_parser.sv
hdl/udp_loopback.sv
hdl/frame_tx_builder.sv
hdl/udp_echo_top.sv
dv/udp_echo_tb.sv

// ==== Bender.yml ====
package:
  name: udp_echo

sources:
  # RTL in compile order, package first.
  - hdl/udp_echo_pkg.sv
  - hdl/frame_rx_parser.sv
  - hdl/udp_loopback.sv
  - hdl/frame_tx_builder.sv
  - hdl/udp_echo_top.sv

  # Testbench, top module udp_echo_tb.
  - target: test
    files:
      - dv/udp_echo_tb.sv
